// File: design/mcoi_app_top.sv
/*
 * stepper controller application layer: buffer loader, system
 * information, motor interlock and readback on the link clock
 */
module mcoi_app_top (
   input  logic                    gbt_rx_clkrs,
   input  logic                    rst_i,
   input  logic [15:0]             ps_status_i,
   input  readback_pkg::word_t     buf_data_i,
   input  readback_pkg::word_t     feedback_i,
   input  motor_pkg::motor_cmds_t  link_cmd_i,
   input  motor_pkg::drv_in_t      drv_in_i,
   input  readback_pkg::word_t     page_sel_i,
   input  logic                    page_valid_i,
   input  logic                    rx_clken_i,
   input  logic [3:0]              pcbrev_i,
   output readback_pkg::buf_addr_t buf_addr_o,
   output logic                    progress_o,
   output motor_pkg::drv_out_t     drv_out_o,
   output motor_pkg::motor_stats_t link_status_o,
   output readback_pkg::word_t     readback_o
);

   readback_pkg::buf_entry_t entry;
   logic                     entry_valid;
   readback_pkg::sysinfo_t   sysinfo;
   motor_pkg::motor_stats_t  status;

   // ------------------------------------------------------------
   // system information load
   // ------------------------------------------------------------
   // bit 3 of the processor status requests a load
   ps_buffer_reader i_ps_buffer_reader (
      .gbt_rx_clkrs  (gbt_rx_clkrs),
      .rst_i         (rst_i),
      .start_i       (ps_status_i[3]),
      .buf_data_i    (buf_data_i),
      .buf_addr_o    (buf_addr_o),
      .entry_o       (entry),
      .entry_valid_o (entry_valid),
      .progress_o    (progress_o)
   );

   sysinfo_regs i_sysinfo_regs (
      .gbt_rx_clkrs  (gbt_rx_clkrs),
      .rst_i         (rst_i),
      .entry_i       (entry),
      .entry_valid_i (entry_valid),
      .progress_i    (progress_o),
      .sysinfo_o     (sysinfo)
   );

   // ------------------------------------------------------------
   // motors and readback
   // ------------------------------------------------------------
   motor_io i_motor_io (
      .gbt_rx_clkrs (gbt_rx_clkrs),
      .rst_i        (rst_i),
      .feedback_i   (feedback_i),
      .link_cmd_i   (link_cmd_i),
      .drv_in_i     (drv_in_i),
      .drv_out_o    (drv_out_o),
      .status_o     (status)
   );

   // same synchronized status feeds the link and the status pages
   assign link_status_o = status;

   readback_mux i_readback_mux (
      .gbt_rx_clkrs (gbt_rx_clkrs),
      .rst_i        (rst_i),
      .page_sel_i   (page_sel_i),
      .page_valid_i (page_valid_i),
      .rx_clken_i   (rx_clken_i),
      .pcbrev_i     (pcbrev_i),
      .sysinfo_i    (sysinfo),
      .status_i     (status),
      .readback_o   (readback_o)
   );

endmodule

// File: design/motor_io.sv
/*
 * motor pins: link commands pass to the drivers only under the
 * interlock, driver status goes back inverted and synchronized
 */
module motor_io (
   input  logic                        gbt_rx_clkrs,
   input  logic                        rst_i,
   input  readback_pkg::word_t         feedback_i,
   input  motor_pkg::motor_cmds_t      link_cmd_i,
   input  motor_pkg::drv_in_t          drv_in_i,
   output motor_pkg::drv_out_t         drv_out_o,
   output motor_pkg::motor_stats_t     status_o
);

   motor_pkg::motor_cmds_t  cmd_q;
   motor_pkg::motor_stats_t stat_raw;
   // stage 0 samples the pins, the last stage is the clean status
   motor_pkg::motor_stats_t sync_q [motor_pkg::SYNC_STAGES];

   // ------------------------------------------------------------
   // command interlock
   // ------------------------------------------------------------
   // all ones sets deactivate on every motor, so a broken loop or a
   // link that is not up yet keeps the drivers off
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         cmd_q <= '1;
      end else if (feedback_i == readback_pkg::INTERLOCK_KEY) begin
         cmd_q <= link_cmd_i;
      end else begin
         cmd_q <= '1;
      end
   end

   // command nibbles to pin groups
   always_comb begin
      for (int m = 0; m < motor_pkg::N_MOTORS; m++) begin
         drv_out_o.pl_boost[m] = cmd_q[m].boost;
         drv_out_o.pl_dir[m]   = cmd_q[m].dir;
         drv_out_o.pl_en[m]    = cmd_q[m].deactivate;
         drv_out_o.pl_clk[m]   = cmd_q[m].step_out;
      end
   end

   // ------------------------------------------------------------
   // status path
   // ------------------------------------------------------------
   // driver outputs are open drain, low means active
   always_comb begin
      for (int m = 0; m < motor_pkg::N_MOTORS; m++) begin
         stat_raw[m].pfail           = ~drv_in_i.pl_pfail[m];
         stat_raw[m].raw_switches[0] = ~drv_in_i.pl_sw_outa[m];
         stat_raw[m].raw_switches[1] = ~drv_in_i.pl_sw_outb[m];
         // no overheat pin on this board
         stat_raw[m].overheat        = 1'b0;
      end
   end

   // pins are asynchronous to the link clock
   always_ff @(posedge gbt_rx_clkrs) begin
      sync_q[0] <= stat_raw;
      for (int s = 1; s < motor_pkg::SYNC_STAGES; s++) begin
         sync_q[s] <= sync_q[s-1];
      end
   end

   assign status_o = sync_q[motor_pkg::SYNC_STAGES-1];

endmodule

// File: design/motor_pkg.sv
/*
 * motor side definitions: motor count, link command and status fields,
 * and the driver pin groups of the stepper drivers
 */
package motor_pkg;

   // ------------------------------------------------------------
   // geometry
   // ------------------------------------------------------------

   // motors served by one fiber
   localparam int N_MOTORS = 16;
   // flip-flop depth of the status synchronizer
   localparam int SYNC_STAGES = 3;

   // one bit per motor, used for every driver pin group
   typedef logic [N_MOTORS-1:0] motor_vec_t;
   // motor index, selects one motor out of the fiber
   typedef logic [$clog2(N_MOTORS)-1:0] motor_idx_t;

   // ------------------------------------------------------------
   // link fields
   // ------------------------------------------------------------

   // command nibble of one motor, step_out on the top bit
   typedef struct packed {
      logic step_out;
      logic deactivate;
      logic dir;
      logic boost;
   } motor_cmd_t;

   // 64-bit command field, motor 0 in the low nibble
   typedef motor_cmd_t [N_MOTORS-1:0] motor_cmds_t;

   // status nibble of one motor, active high
   typedef struct packed {
      logic       pfail;
      logic [1:0] raw_switches;
      logic       overheat;
   } motor_stat_t;

   // 64-bit status field sent back over the link
   typedef motor_stat_t [N_MOTORS-1:0] motor_stats_t;

   // ------------------------------------------------------------
   // driver pins
   // ------------------------------------------------------------

   // outputs towards the drivers, pl_en high deactivates a motor
   typedef struct packed {
      motor_vec_t pl_boost;
      motor_vec_t pl_dir;
      motor_vec_t pl_en;
      motor_vec_t pl_clk;
   } drv_out_t;

   // inputs from the drivers, all active low
   typedef struct packed {
      motor_vec_t pl_pfail;
      motor_vec_t pl_sw_outa;
      motor_vec_t pl_sw_outb;
   } drv_in_t;

endpackage

// File: design/ps_buffer_reader.sv
/*
 * processor buffer reader: sweeps the shared buffer once per start
 * request and hands out each word as a tag and a value
 */
module ps_buffer_reader (
   input  logic                     gbt_rx_clkrs,
   input  logic                     rst_i,
   input  logic                     start_i,
   input  readback_pkg::word_t      buf_data_i,
   output readback_pkg::buf_addr_t  buf_addr_o,
   output readback_pkg::buf_entry_t entry_o,
   output logic                     entry_valid_o,
   output logic                     progress_o
);

   // address of the final word of a sweep
   localparam readback_pkg::buf_addr_t LAST_ADDR =
      readback_pkg::buf_addr_t'(readback_pkg::N_BUF_WORDS - 1);

   readback_pkg::fsm_state_t state_q;
   readback_pkg::buf_addr_t  addr_q;
   logic                     valid_q;

   // ------------------------------------------------------------
   // sweep FSM
   // ------------------------------------------------------------
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         state_q <= readback_pkg::WAIT_FOR_START;
         addr_q  <= '0;
         valid_q <= 1'b0;
      end else begin
         // buffer answers one cycle later, so the strobe lags the address
         valid_q <= (state_q == readback_pkg::READ_ALL_DATA);
         case (state_q)
            readback_pkg::WAIT_FOR_START: begin
               addr_q <= '0;
               // processor sets bit 3 of its status when data is ready
               if (start_i) begin
                  state_q <= readback_pkg::READ_ALL_DATA;
               end
            end
            readback_pkg::READ_ALL_DATA: begin
               // wraps back to zero after the last word
               addr_q <= addr_q + readback_pkg::buf_addr_t'(1);
               if (addr_q == LAST_ADDR) begin
                  state_q <= readback_pkg::FINISHED;
               end
            end
            readback_pkg::FINISHED: begin
               // gives the last entry its cycle before progress drops
               state_q <= readback_pkg::WAIT_FOR_START;
            end
            default: begin
               state_q <= readback_pkg::WAIT_FOR_START;
            end
         endcase
      end
   end

   assign buf_addr_o = addr_q;
   // processor polls this to see the load is running
   assign progress_o = (state_q != readback_pkg::WAIT_FOR_START);

   // word layout: tag in 31:24, reserved 23:16, value 15:0
   assign entry_o.tag    = buf_data_i[31:24];
   assign entry_o.value  = buf_data_i[15:0];
   assign entry_valid_o  = valid_q;

endmodule

// File: design/readback_mux.sv
/*
 * readback multiplexer: loopback register and the word answered for
 * the page currently selected by the back-end
 */
module readback_mux (
   input  logic                    gbt_rx_clkrs,
   input  logic                    rst_i,
   input  readback_pkg::word_t     page_sel_i,
   input  logic                    page_valid_i,
   input  logic                    rx_clken_i,
   input  logic [3:0]              pcbrev_i,
   input  readback_pkg::sysinfo_t  sysinfo_i,
   input  motor_pkg::motor_stats_t status_i,
   output readback_pkg::word_t     readback_o
);

   // zero padding above a status nibble
   localparam int STAT_PAD = $bits(readback_pkg::word_t) - $bits(motor_pkg::motor_stat_t);

   readback_pkg::word_t   loopback_q;
   readback_pkg::word_t   readback_q;
   readback_pkg::word_t   mux_word;
   readback_pkg::page_t   page;
   motor_pkg::motor_idx_t motor_idx;

   // loopback echoes bit 31 so the back-end can check the path
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         loopback_q <= readback_pkg::word_t'(1);
      end else if (page_valid_i) begin
         loopback_q <= {page_sel_i[31], 30'b0, 1'b1};
      end
   end

   // ------------------------------------------------------------
   // page decode
   // ------------------------------------------------------------
   assign page      = page_sel_i[7:0];
   assign motor_idx = motor_pkg::motor_idx_t'(page - readback_pkg::PAGE_MOTOR0);

   always_comb begin
      case (page)
         readback_pkg::PAGE_LOOPBACK: mux_word = loopback_q;
         readback_pkg::PAGE_BUILD:    mux_word = readback_pkg::BUILD_WORD;
         readback_pkg::PAGE_PCBREV:   mux_word = readback_pkg::word_t'(pcbrev_i);
         readback_pkg::PAGE_UID_HI:   mux_word = sysinfo_i.uid[63:32];
         readback_pkg::PAGE_UID_LO:   mux_word = sysinfo_i.uid[31:0];
         readback_pkg::PAGE_TEMP:     mux_word = sysinfo_i.temp;
         readback_pkg::PAGE_POWER:    mux_word = sysinfo_i.power;
         readback_pkg::PAGE_ONE:      mux_word = readback_pkg::word_t'(1);
         default: begin
            // one status page per motor, everything else is unknown
            if (page >= readback_pkg::PAGE_MOTOR0 &&
                page < readback_pkg::PAGE_MOTOR0 + motor_pkg::N_MOTORS) begin
               mux_word = {{STAT_PAD{1'b0}}, status_i[motor_idx]};
            end else begin
               mux_word = readback_pkg::UNKNOWN_PAGE;
            end
         end
      endcase
   end

   // word only moves on link clock enable cycles
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         readback_q <= '0;
      end else if (rx_clken_i) begin
         readback_q <= mux_word;
      end
   end

   assign readback_o = readback_q;

endmodule

// File: design/readback_pkg.sv
/*
 * readback side definitions: shared buffer layout, register tags,
 * readback page numbers and the fixed words of the link
 */
package readback_pkg;

   // link words and buffer payload
   typedef logic [31:0] word_t;
   typedef logic [15:0] half_t;
   typedef logic [7:0]  reg_tag_t;
   // readback page number, low byte of the page selector
   typedef logic [7:0]  page_t;
   typedef logic [127:0] uid_t;

   // ------------------------------------------------------------
   // shared buffer
   // ------------------------------------------------------------

   localparam int BUF_ADDR_W = 4;
   // words read during one load
   localparam int N_BUF_WORDS = 2 ** BUF_ADDR_W;

   typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

   // one tagged word, reserved byte already stripped
   typedef struct packed {
      reg_tag_t tag;
      half_t    value;
   } buf_entry_t;

   // system information as seen by the readback
   typedef struct packed {
      uid_t  uid;
      word_t power;
      word_t temp;
   } sysinfo_t;

   // buffer sweep states
   typedef enum logic [1:0] {
      WAIT_FOR_START,
      READ_ALL_DATA,
      FINISHED
   } fsm_state_t;

   // register tags, uid slices lowest first (tag 3 is not used)
   localparam reg_tag_t TAG_UID0  = 8'd1;
   localparam reg_tag_t TAG_UID1  = 8'd2;
   localparam reg_tag_t TAG_UID2  = 8'd4;
   localparam reg_tag_t TAG_UID3  = 8'd5;
   localparam reg_tag_t TAG_UID4  = 8'd6;
   localparam reg_tag_t TAG_UID5  = 8'd7;
   localparam reg_tag_t TAG_UID6  = 8'd8;
   localparam reg_tag_t TAG_UID7  = 8'd9;
   localparam reg_tag_t TAG_POWER = 8'd10;
   localparam reg_tag_t TAG_TEMP  = 8'd13;

   // ------------------------------------------------------------
   // readback pages
   // ------------------------------------------------------------

   localparam page_t PAGE_LOOPBACK = 8'd0;
   localparam page_t PAGE_BUILD    = 8'd1;
   localparam page_t PAGE_PCBREV   = 8'd2;
   localparam page_t PAGE_UID_HI   = 8'd3;
   localparam page_t PAGE_UID_LO   = 8'd4;
   localparam page_t PAGE_TEMP     = 8'd5;
   localparam page_t PAGE_POWER    = 8'd6;
   localparam page_t PAGE_ONE      = 8'd7;
   // first of the per-motor status pages
   localparam page_t PAGE_MOTOR0   = 8'd16;

   // fixed words
   localparam word_t BUILD_WORD    = 32'h4d43_0102;
   localparam word_t INTERLOCK_KEY = 32'ha5c3_3c5a;
   localparam word_t UNKNOWN_PAGE  = 32'hdeadbeef;

endpackage

// File: design/sysinfo_regs.sv
/*
 * system information registers: unique ID, power and temperature filled
 * by tag, with a copy that only moves while no load runs
 */
module sysinfo_regs (
   input  logic                     gbt_rx_clkrs,
   input  logic                     rst_i,
   input  readback_pkg::buf_entry_t entry_i,
   input  logic                     entry_valid_i,
   input  logic                     progress_i,
   output readback_pkg::sysinfo_t   sysinfo_o
);

   // working copy, written slice by slice
   readback_pkg::sysinfo_t work_q;
   // stable copy for the readback
   readback_pkg::sysinfo_t snap_q;

   // ------------------------------------------------------------
   // tag demux
   // ------------------------------------------------------------
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         work_q <= '0;
      end else if (entry_valid_i) begin
         case (entry_i.tag)
            readback_pkg::TAG_UID0:  work_q.uid[15:0]    <= entry_i.value;
            readback_pkg::TAG_UID1:  work_q.uid[31:16]   <= entry_i.value;
            readback_pkg::TAG_UID2:  work_q.uid[47:32]   <= entry_i.value;
            readback_pkg::TAG_UID3:  work_q.uid[63:48]   <= entry_i.value;
            readback_pkg::TAG_UID4:  work_q.uid[79:64]   <= entry_i.value;
            readback_pkg::TAG_UID5:  work_q.uid[95:80]   <= entry_i.value;
            readback_pkg::TAG_UID6:  work_q.uid[111:96]  <= entry_i.value;
            readback_pkg::TAG_UID7:  work_q.uid[127:112] <= entry_i.value;
            // sensors deliver 16 bits, upper halves stay zero
            readback_pkg::TAG_POWER: work_q.power[15:0]  <= entry_i.value;
            readback_pkg::TAG_TEMP:  work_q.temp[15:0]   <= entry_i.value;
            default: begin
               // unknown or reserved tag, keep everything
               work_q <= work_q;
            end
         endcase
      end
   end

   // ------------------------------------------------------------
   // idle-time snapshot
   // ------------------------------------------------------------
   // frozen during a load so a half-written uid never shows up
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         snap_q <= '0;
      end else if (!progress_i) begin
         snap_q <= work_q;
      end
   end

   assign sysinfo_o = snap_q;

endmodule

// File: mcoi_app.f
+incdir+test
design/motor_pkg.sv
design/readback_pkg.sv
design/ps_buffer_reader.sv
design/sysinfo_regs.sv
design/motor_io.sv
design/readback_mux.sv
design/mcoi_app_top.sv
test/tb_mcoi_app.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_mcoi_app -f mcoi_app.f \
   && ./obj_dir/Vtb_mcoi_app > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

// File: test/app_model.svh
/*
 * reference model for the application layer: expected driver pins,
 * synchronized status, loaded system information and readback words
 */
`ifndef APP_MODEL_SVH
`define APP_MODEL_SVH

// driver pins one cycle after a command, all ones keeps every motor off
function automatic motor_pkg::drv_out_t expected_pins(input motor_pkg::motor_cmds_t cmd,
                                                      input readback_pkg::word_t fb);
   motor_pkg::drv_out_t pins;
   pins = '1;
   if (fb == readback_pkg::INTERLOCK_KEY) begin
      for (int m = 0; m < motor_pkg::N_MOTORS; m++) begin
         pins.pl_boost[m] = cmd[m].boost;
         pins.pl_dir[m]   = cmd[m].dir;
         pins.pl_en[m]    = cmd[m].deactivate;
         pins.pl_clk[m]   = cmd[m].step_out;
      end
   end
   return pins;
endfunction

// driver inputs are active low, no overheat pin
function automatic motor_pkg::motor_stats_t expected_status(input motor_pkg::drv_in_t drv);
   motor_pkg::motor_stats_t st;
   for (int m = 0; m < motor_pkg::N_MOTORS; m++) begin
      st[m] = {~drv.pl_pfail[m], ~drv.pl_sw_outb[m], ~drv.pl_sw_outa[m], 1'b0};
   end
   return st;
endfunction

// uid slice filled by a tag, -1 for anything else
function automatic int uid_slice(input readback_pkg::reg_tag_t tag);
   case (tag)
      readback_pkg::TAG_UID0: return 0;
      readback_pkg::TAG_UID1: return 1;
      readback_pkg::TAG_UID2: return 2;
      readback_pkg::TAG_UID3: return 3;
      readback_pkg::TAG_UID4: return 4;
      readback_pkg::TAG_UID5: return 5;
      readback_pkg::TAG_UID6: return 6;
      readback_pkg::TAG_UID7: return 7;
      default: return -1;
   endcase
endfunction

// whole buffer in address order, so a repeated tag keeps its last value
function automatic readback_pkg::sysinfo_t model_sysinfo(
   input readback_pkg::word_t words [readback_pkg::N_BUF_WORDS]);
   readback_pkg::sysinfo_t info;
   readback_pkg::reg_tag_t tag;
   int slice;
   info = '0;
   for (int a = 0; a < readback_pkg::N_BUF_WORDS; a++) begin
      tag   = words[a][31:24];
      slice = uid_slice(tag);
      if (slice >= 0) info.uid[slice*16 +: 16] = words[a][15:0];
      else if (tag == readback_pkg::TAG_POWER) info.power[15:0] = words[a][15:0];
      else if (tag == readback_pkg::TAG_TEMP) info.temp[15:0] = words[a][15:0];
   end
   return info;
endfunction

// word answered for a page selector
function automatic readback_pkg::word_t expected_page(input readback_pkg::word_t sel,
                                                      input readback_pkg::word_t loopback,
                                                      input logic [3:0] pcbrev,
                                                      input readback_pkg::sysinfo_t info,
                                                      input motor_pkg::motor_stats_t stat);
   int page;
   page = int'(sel[7:0]);
   case (page)
      0: return loopback;
      1: return readback_pkg::BUILD_WORD;
      2: return {28'b0, pcbrev};
      3: return info.uid[63:32];
      4: return info.uid[31:0];
      5: return info.temp;
      6: return info.power;
      7: return 32'd1;
      default: begin
         if (page >= 16 && page < 16 + motor_pkg::N_MOTORS) return {28'b0, stat[page - 16]};
         return readback_pkg::UNKNOWN_PAGE;
      end
   endcase
endfunction

`endif

// File: test/tb_mcoi_app.sv
/*
 * testbench for the stepper controller application layer
 * with random stimulus checked against the reference model
 */
module tb_mcoi_app;

   logic                    gbt_rx_clkrs = 1'b0;
   logic                    rst_i;
   logic [15:0]             ps_status_i;
   readback_pkg::word_t     buf_data_i = '0;
   readback_pkg::word_t     feedback_i;
   motor_pkg::motor_cmds_t  link_cmd_i;
   motor_pkg::drv_in_t      drv_in_i;
   readback_pkg::word_t     page_sel_i;
   logic                    page_valid_i;
   logic                    rx_clken_i;
   logic [3:0]              pcbrev_i;
   readback_pkg::buf_addr_t buf_addr_o;
   logic                    progress_o;
   motor_pkg::drv_out_t     drv_out_o;
   motor_pkg::motor_stats_t link_status_o;
   readback_pkg::word_t     readback_o;

   // shared buffer model with the address sampled on the rising edge
   readback_pkg::word_t     buf_mem [readback_pkg::N_BUF_WORDS];
   readback_pkg::buf_addr_t addr_smp = '0;

   // every tag once plus unknown ones and a second uid3 and temp
   readback_pkg::reg_tag_t load_tags [readback_pkg::N_BUF_WORDS] = '{
      readback_pkg::TAG_TEMP, readback_pkg::TAG_UID3, 8'd3, readback_pkg::TAG_UID0,
      readback_pkg::TAG_POWER, readback_pkg::TAG_UID7, 8'hff, readback_pkg::TAG_UID1,
      readback_pkg::TAG_UID5, readback_pkg::TAG_UID2, readback_pkg::TAG_UID4,
      readback_pkg::TAG_UID6, readback_pkg::TAG_UID3, 8'd11, readback_pkg::TAG_TEMP, 8'd0};

   // model state
   readback_pkg::word_t     loop_model;
   readback_pkg::sysinfo_t  info_model;
   motor_pkg::motor_stats_t stat_model;

   int    seed;
   string cur_test;
   int    test_errs;
   int    total_errs;
   int    n_tests;
   int    n_failed;

   `include "app_model.svh"

   mcoi_app_top i_dut (
      .gbt_rx_clkrs  (gbt_rx_clkrs),
      .rst_i         (rst_i),
      .ps_status_i   (ps_status_i),
      .buf_data_i    (buf_data_i),
      .feedback_i    (feedback_i),
      .link_cmd_i    (link_cmd_i),
      .drv_in_i      (drv_in_i),
      .page_sel_i    (page_sel_i),
      .page_valid_i  (page_valid_i),
      .rx_clken_i    (rx_clken_i),
      .pcbrev_i      (pcbrev_i),
      .buf_addr_o    (buf_addr_o),
      .progress_o    (progress_o),
      .drv_out_o     (drv_out_o),
      .link_status_o (link_status_o),
      .readback_o    (readback_o)
   );

   always #50 gbt_rx_clkrs = ~gbt_rx_clkrs;

   // buffer answers one cycle after the address
   always @(posedge gbt_rx_clkrs) addr_smp <= buf_addr_o;
   always @(negedge gbt_rx_clkrs) buf_data_i <= buf_mem[addr_smp];

   // ------------------------------------------------------------
   // bookkeeping
   // ------------------------------------------------------------
   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = 0;
      n_tests++;
   endtask

   task automatic end_test();
      if (test_errs == 0) $display("test %s: ok", cur_test);
      else $display("test %s: %0d errors", cur_test, test_errs);
      if (test_errs != 0) n_failed++;
      total_errs += test_errs;
   endtask

   task automatic compare_value(input logic [63:0] exp_v, input logic [63:0] act_v);
      if (act_v !== exp_v) begin
         $display("Mismatch in %s: expected %h, actual %h", cur_test, exp_v, act_v);
         test_errs++;
      end
   endtask

   // all tasks below start and end on a falling edge
   task automatic check_page(input readback_pkg::word_t sel);
      page_sel_i = sel;
      rx_clken_i = 1'b1;
      @(negedge gbt_rx_clkrs);
      compare_value(expected_page(sel, loop_model, pcbrev_i, info_model, stat_model),
                    readback_o);
   endtask

   task automatic wait_progress(input logic level, input int limit);
      int n;
      n = 0;
      while (progress_o !== level && n < limit) begin
         @(negedge gbt_rx_clkrs);
         n++;
      end
      if (progress_o !== level) begin
         $display("Timeout in %s: progress never went %s", cur_test, level ? "high" : "low");
         test_errs++;
      end
   endtask

   // ------------------------------------------------------------
   // tests
   // ------------------------------------------------------------
   task automatic reset_state();
      start_test("reset_state");
      compare_value('1, drv_out_o);
      compare_value('0, progress_o);
      compare_value('0, readback_o);
      check_page(readback_pkg::PAGE_LOOPBACK);
      end_test();
   endtask

   task automatic interlock_random();
      motor_pkg::drv_out_t exp_pins;
      start_test("interlock");
      exp_pins = '1;
      // check the previous command while the next one is driven
      for (int i = 0; i <= 200; i++) begin
         @(negedge gbt_rx_clkrs);
         if (i > 0) compare_value(exp_pins, drv_out_o);
         link_cmd_i = {$random(seed), $random(seed)};
         if (($random(seed) & 1) != 0) feedback_i = readback_pkg::INTERLOCK_KEY;
         else feedback_i = $random(seed);
         exp_pins = expected_pins(link_cmd_i, feedback_i);
      end
      feedback_i = '0;
      end_test();
   endtask

   task automatic status_sync();
      logic [63:0]             rnd;
      motor_pkg::motor_stats_t old_stat;
      start_test("status_sync");
      for (int i = 0; i < 20; i++) begin
         old_stat   = stat_model;
         rnd        = {$random(seed), $random(seed)};
         drv_in_i   = rnd[47:0];
         stat_model = expected_status(drv_in_i);
         // old value holds for two cycles and the new one shows on the third
         repeat (2) @(negedge gbt_rx_clkrs);
         compare_value(old_stat, link_status_o);
         @(negedge gbt_rx_clkrs);
         compare_value(stat_model, link_status_o);
      end
      for (int m = 0; m < motor_pkg::N_MOTORS; m++) begin
         check_page(32'(readback_pkg::PAGE_MOTOR0) + 32'(m));
      end
      end_test();
   endtask

   task automatic sysinfo_load();
      readback_pkg::word_t rnd;
      start_test("sysinfo_load");
      for (int a = 0; a < readback_pkg::N_BUF_WORDS; a++) begin
         rnd        = $random(seed);
         buf_mem[a] = {load_tags[a], rnd[23:0]};
      end
      info_model  = model_sysinfo(buf_mem);
      ps_status_i = 16'($random(seed)) | 16'h0008;
      wait_progress(1'b1, 4);
      // drop the request so no second sweep starts
      ps_status_i = ps_status_i & ~16'h0008;
      // sweep presents one address per cycle from the first word up
      for (int a = 0; a < readback_pkg::N_BUF_WORDS; a++) begin
         compare_value(readback_pkg::buf_addr_t'(a), buf_addr_o);
         @(negedge gbt_rx_clkrs);
      end
      wait_progress(1'b0, 30);
      // snapshot catches up within two cycles
      repeat (2) @(negedge gbt_rx_clkrs);
      for (int p = 3; p <= 6; p++) begin
         check_page(32'(p));
      end
      end_test();
   endtask

   task automatic page_readback();
      readback_pkg::word_t sel;
      readback_pkg::word_t held;
      start_test("page_readback");
      // loopback with bit 31 set and then cleared
      for (int i = 0; i < 2; i++) begin
         sel          = $random(seed);
         sel[31]      = (i == 0);
         sel[7:0]     = readback_pkg::PAGE_LOOPBACK;
         page_sel_i   = sel;
         page_valid_i = 1'b1;
         @(negedge gbt_rx_clkrs);
         page_valid_i = 1'b0;
         loop_model   = {sel[31], 30'b0, 1'b1};
         check_page(sel);
      end
      pcbrev_i = 4'($random(seed));
      check_page(readback_pkg::PAGE_BUILD);
      check_page(readback_pkg::PAGE_PCBREV);
      check_page(readback_pkg::PAGE_ONE);
      // pages 128 and up are never listed
      sel    = $random(seed);
      sel[7] = 1'b1;
      check_page(sel);
      held       = expected_page(sel, loop_model, pcbrev_i, info_model, stat_model);
      rx_clken_i = 1'b0;
      page_sel_i = 32'(readback_pkg::PAGE_ONE);
      repeat (3) @(negedge gbt_rx_clkrs);
      compare_value(held, readback_o);
      end_test();
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial begin
      seed         = 32'h81522814;
      rst_i        = 1'b1;
      ps_status_i  = '0;
      feedback_i   = '0;
      link_cmd_i   = '0;
      drv_in_i     = '1;
      page_sel_i   = '0;
      page_valid_i = 1'b0;
      rx_clken_i   = 1'b0;
      pcbrev_i     = '0;
      loop_model   = 32'd1;
      info_model   = '0;
      stat_model   = '0;
      total_errs   = 0;
      n_tests      = 0;
      n_failed     = 0;
      for (int a = 0; a < readback_pkg::N_BUF_WORDS; a++) begin
         buf_mem[a] = {8'hff, 8'h00, 16'(a) * 16'h1111};
      end
      repeat (3) @(negedge gbt_rx_clkrs);
      rst_i = 1'b0;
      reset_state();
      interlock_random();
      status_sync();
      sysinfo_load();
      page_readback();
      $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_errs);
      if (total_errs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule
